// ==== irq_stim.txt ====
# op and fields in hex: P mask, W host addr data, R host addr expect
# Y ready_on, E vector, I cycles; host 0 is the core, 1 is debug
Y 1
W 0 0 0008
P 0008
E 3
R 0 1 0000
P 0200
I 10
R 1 1 0200
W 0 0 0208
E 9
W 1 0 8421
P 8421
E f
E a
E 5
E 0
I 8
Y 0
P 8021
E f
E 5
E 0
Y 1
W 0 0 0041
R 1 1 0000
R 0 0 0041
W 1 1 0040
E 6
W 1 1 0100
I 2
W 0 2 0100
W 0 0 0141
I 12
R 0 1 0000

// ==== flist.f ====
irq_pkg.sv
irq_pending.sv
irq_prio_pipe.sv
irq_dispatch.sv
reg_arbiter.sv
irq_ctrl_top.sv
irq_ctrl_sva.sv
irq_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: irq_ctrl

sources:
  - irq_pkg.sv
  - irq_pending.sv
  - irq_prio_pipe.sv
  - irq_dispatch.sv
  - reg_arbiter.sv
  - irq_ctrl_top.sv
  - target: test
    files:
      - irq_ctrl_sva.sv
      - irq_ctrl_tb.sv

// ==== irq_ctrl_tb.sv ====
// testbench for the interrupt controller with file stimulus, reference model and watchdog
`timescale 1ns/100ps

module irq_ctrl_tb
    import irq_pkg::*;
();

    logic           clk;
    logic           rst_n;
    irq_mask_t      irq_src;
    logic [1:0]     host_valid;
    reg_req_t [1:0] host_req;
    logic [1:0]     host_ready;
    logic [1:0]     rsp_valid;
    reg_data_t      rsp_rdata;
    logic           irq_valid;
    irq_vec_t       irq_vec;
    logic           irq_ready;

    // reference state and bookkeeping
    irq_mask_t  model_pend;
    irq_mask_t  model_en;
    logic       ready_on;
    logic [1:0] busy;
    int         mismatches;
    int         failures;
    int         watch_cycles;
    integer     seed;
    string      lines[$];

    irq_ctrl_top irq_ctrl_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq_src    (irq_src),
        .host_valid (host_valid),
        .host_req   (host_req),
        .host_ready (host_ready),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .irq_valid  (irq_valid),
        .irq_vec    (irq_vec),
        .irq_ready  (irq_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #0.5;
    endtask

    function automatic irq_vec_t highest_set(irq_mask_t m);
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (m[i]) begin
                return irq_vec_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic reg_data_t model_read(reg_addr_t addr);
        case (addr)
            REG_ENABLE:  return model_en;
            REG_PENDING: return model_pend;
            default:     return '0;
        endcase
    endfunction

    task automatic model_write(reg_addr_t addr, reg_data_t data);
        case (addr)
            REG_ENABLE:  model_en = data;
            REG_PENDING: model_pend = model_pend | data;
            REG_CLEAR:   model_pend = model_pend & ~data;
            default:     ;
        endcase
    endtask

    // one request on a host channel
    // data is wdata for a write and the expected value for a read
    task automatic host_op(input int h, input logic wr, input reg_addr_t addr,
                           input reg_data_t data);
        reg_data_t model_rd;
        reg_data_t exp_rd;
        int        waited;
        waited = 0;
        host_req[h].write = wr;
        host_req[h].addr  = addr;
        host_req[h].wdata = wr ? data : '0;
        host_valid[h]     = 1'b1;
        #1;
        while (!host_ready[h] && waited < 8) begin
            tick();
            #1;
            waited++;
        end
        if (!host_ready[h]) begin
            $display("host %0d request was never accepted, at %0t", h, $time);
            failures++;
            tick();
        end else begin
            model_rd = model_read(addr);
            exp_rd   = wr ? '0 : data;
            tick();
            if (wr) begin
                model_write(addr, data);
            end
            if (!rsp_valid[h]) begin
                $display("host %0d got no response after acceptance, at %0t", h, $time);
                failures++;
            end else if (rsp_valid[1 - h]) begin
                $display("MISMATCH at %0t: response for host %0d also raised for host %0d",
                         $time, h, 1 - h);
                mismatches++;
            end else if (rsp_rdata !== exp_rd) begin
                $display("MISMATCH at %0t: host %0d addr %0d rdata %h, expected %h",
                         $time, h, addr, rsp_rdata, exp_rd);
                mismatches++;
            end else if (!wr && rsp_rdata !== model_rd) begin
                $display("MISMATCH at %0t: host %0d rdata %h, model has %h",
                         $time, h, rsp_rdata, model_rd);
                mismatches++;
            end
        end
        host_valid[h] = 1'b0;
        busy[h]       = 1'b0;
    endtask

    task automatic launch_host(input int h, input logic wr, input reg_addr_t addr,
                               input reg_data_t data);
        wait (!busy[h]);
        busy[h] = 1'b1;
        fork
            host_op(h, wr, addr, data);
        join_none
    endtask

    task automatic pulse(input irq_mask_t m);
        irq_src = m;
        tick();
        irq_src = '0;
        tick();
        model_pend = model_pend | m;
    endtask

    task automatic expect_irq(input irq_vec_t v);
        irq_vec_t held;
        int       n;
        n = 0;
        while (!irq_valid && n < 8) begin
            tick();
            n++;
        end
        if (!irq_valid) begin
            $display("no interrupt raised within 8 cycles, expected vector %0d at %0t", v, $time);
            failures++;
            return;
        end
        if (irq_vec !== v) begin
            $display("MISMATCH at %0t: irq_vec %0d, expected %0d", $time, irq_vec, v);
            mismatches++;
        end
        if (highest_set(model_pend & model_en) != v) begin
            $display("MISMATCH at %0t: model picks %0d, file expects %0d",
                     $time, highest_set(model_pend & model_en), v);
            mismatches++;
        end
        held = irq_vec;
        // core stalls for a random gap
        if (!ready_on) begin
            repeat (1 + ($random(seed) & 7)) begin
                tick();
                if (!irq_valid || irq_vec !== held) begin
                    $display("MISMATCH at %0t: vector %0d not held under back-pressure",
                             $time, held);
                    mismatches++;
                end
            end
        end
        irq_ready = 1'b1;
        tick();
        irq_ready = 1'b0;
        model_pend[v] = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            tick();
            if ((model_pend & model_en) == '0 && irq_valid) begin
                $display("MISMATCH at %0t: irq_valid high with nothing enabled and pending",
                         $time);
                mismatches++;
            end
        end
    endtask

    task automatic run_line(input string line);
        byte op;
        int  a;
        int  b;
        int  c;
        void'($sscanf(line, "%c %h %h %h", op, a, b, c));
        if (op != "W" && op != "R") begin
            wait (busy == 2'b00);
        end
        case (op)
            "P":     pulse(irq_mask_t'(a));
            "W":     launch_host(a, 1'b1, reg_addr_t'(b), reg_data_t'(c));
            "R":     launch_host(a, 1'b0, reg_addr_t'(b), reg_data_t'(c));
            "Y":     ready_on = (a != 0);
            "E":     expect_irq(irq_vec_t'(a));
            "I":     idle(a);
            default: begin
                $display("unknown command in stimulus file: %s", line);
                failures++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        seed         = 32'hfa55_d7c6;
        rst_n        = 1'b0;
        irq_src      = '0;
        host_valid   = '0;
        host_req     = '0;
        irq_ready    = 1'b0;
        model_pend   = '0;
        model_en     = '0;
        ready_on     = 1'b1;
        busy         = '0;
        mismatches   = 0;
        failures     = 0;
        fd = $fopen("irq_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file irq_stim.txt");
            failures++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        watch_cycles = 10 + 40 * lines.size();
        repeat (10) @(posedge clk);
        #0.5;
        if (irq_valid !== 1'b0 || host_ready !== 2'b00 || rsp_valid !== 2'b00) begin
            $display("MISMATCH at %0t: outputs not low in reset, irq_valid %b ready %b rsp %b",
                     $time, irq_valid, host_ready, rsp_valid);
            mismatches++;
        end
        rst_n = 1'b1;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        wait (busy == 2'b00);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("watchdog timeout, stimulus not finished after %0d cycles", watch_cycles);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== irq_ctrl_sva.sv ====
// bound assertions on the dispatch handshake and on arbiter grants
`timescale 1ns/100ps

module irq_ctrl_sva
    import irq_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       irq_valid,
    input logic       irq_ready,
    input irq_vec_t   irq_vec,
    input logic       claim_valid,
    input logic [1:0] host_ready
);

    // vector held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        irq_valid && !irq_ready |=> irq_valid && $stable(irq_vec))
        else $error("irq_vec changed while irq_ready was low");

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(host_ready))
        else $error("more than one host granted in one cycle");

    // claim is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) claim_valid |=> !claim_valid)
        else $error("claim_valid high for more than one cycle");

endmodule

bind irq_dispatch irq_ctrl_sva dispatch_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_valid   (irq_valid),
    .irq_ready   (irq_ready),
    .irq_vec     (irq_vec),
    .claim_valid (claim_valid),
    .host_ready  (2'b00)
);

bind reg_arbiter irq_ctrl_sva arbiter_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_valid   (1'b0),
    .irq_ready   (1'b0),
    .irq_vec     ('0),
    .claim_valid (1'b0),
    .host_ready  (host_ready)
);

// ==== irq_ctrl_top.sv ====
// interrupt controller top with register arbiter, pending, priority pipeline and dispatch
`timescale 1ns/100ps

module irq_ctrl_top
    import irq_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  irq_mask_t      irq_src,
    input  logic [1:0]     host_valid,
    input  reg_req_t [1:0] host_req,
    output logic [1:0]     host_ready,
    output logic [1:0]     rsp_valid,
    output reg_data_t      rsp_rdata,
    output logic           irq_valid,
    output irq_vec_t       irq_vec,
    input  logic           irq_ready
);

    logic      bus_valid;
    reg_req_t  bus_req;
    reg_data_t bus_rdata;
    irq_mask_t active;
    logic      pick_valid;
    irq_vec_t  pick_vec;
    logic      claim_valid;
    irq_vec_t  claim_vec;

    reg_arbiter reg_arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_valid (host_valid),
        .host_req   (host_req),
        .host_ready (host_ready),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .bus_valid  (bus_valid),
        .bus_req    (bus_req),
        .bus_rdata  (bus_rdata)
    );

    irq_pending irq_pending_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_src     (irq_src),
        .bus_valid   (bus_valid),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .claim_valid (claim_valid),
        .claim_vec   (claim_vec),
        .active      (active)
    );

    irq_prio_pipe irq_prio_pipe_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (active),
        .pick_valid (pick_valid),
        .pick_vec   (pick_vec)
    );

    irq_dispatch irq_dispatch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pick_valid  (pick_valid),
        .pick_vec    (pick_vec),
        .active      (active),
        .irq_valid   (irq_valid),
        .irq_vec     (irq_vec),
        .irq_ready   (irq_ready),
        .claim_valid (claim_valid),
        .claim_vec   (claim_vec)
    );

endmodule

// ==== reg_arbiter.sv ====
// round-robin arbiter of two hosts onto one register bus with registered response
`timescale 1ns/100ps

module reg_arbiter
    import irq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [1:0]           host_valid,
    input  reg_req_t [1:0]       host_req,
    output logic [1:0]           host_ready,
    output logic [1:0]           rsp_valid,
    output reg_data_t            rsp_rdata,
    output logic                 bus_valid,
    output reg_req_t             bus_req,
    input  reg_data_t            bus_rdata
);

    host_sel_t ptr;
    host_sel_t gnt;
    host_sel_t rsp_host;
    logic      rsp_pend;

    // priority host wins when both request
    always_comb begin
        gnt = host_valid[ptr] ? ptr : ~ptr;
    end

    assign bus_valid = |host_valid;
    assign bus_req   = host_req[gnt];

    always_comb begin
        host_ready = '0;
        if (bus_valid) begin
            host_ready[gnt] = 1'b1;
        end
    end

    // other host goes first after a grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= 1'b0;
            rsp_pend <= 1'b0;
            rsp_host <= 1'b0;
        end else begin
            rsp_pend <= bus_valid;
            if (bus_valid) begin
                ptr      <= ~gnt;
                rsp_host <= gnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_valid) begin
            rsp_rdata <= bus_rdata;
        end
    end

    // response only to the host that was accepted
    assign rsp_valid = rsp_pend ? (2'b01 << rsp_host) : 2'b00;

endmodule

// ==== irq_dispatch.sv ====
// single-entry dispatch slot toward the core with stale-pick filter and claim
`timescale 1ns/100ps

module irq_dispatch
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pick_valid,
    input  irq_vec_t  pick_vec,
    input  irq_mask_t active,
    output logic      irq_valid,
    output irq_vec_t  irq_vec,
    input  logic      irq_ready,
    output logic      claim_valid,
    output irq_vec_t  claim_vec
);

    logic     slot_full;
    irq_vec_t slot_vec;
    logic     load;
    logic     take;

    // pick must still be pending and enabled
    assign load = !slot_full && pick_valid && active[pick_vec];
    assign take = slot_full && irq_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full <= 1'b0;
        end else if (take) begin
            slot_full <= 1'b0;
        end else if (load) begin
            slot_full <= 1'b1;
        end
    end

    // vector only changes while the slot is empty
    always_ff @(posedge clk) begin
        if (load) begin
            slot_vec <= pick_vec;
        end
    end

    assign irq_valid = slot_full;
    assign irq_vec   = slot_vec;

    // handshake clears the pending bit at the same edge
    assign claim_valid = take;
    assign claim_vec   = slot_vec;

endmodule

// ==== irq_prio_pipe.sv ====
// four-stage pipelined highest-index priority encoder over the active vector
`timescale 1ns/100ps

module irq_prio_pipe
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  irq_mask_t active,
    output logic      pick_valid,
    output irq_vec_t  pick_vec
);

    irq_mask_t s1_act;
    irq_mask_t s2_act;
    irq_mask_t s3_act;
    irq_vec_t  s1_vec;
    irq_vec_t  s2_vec;
    irq_vec_t  s3_vec;
    irq_vec_t  s4_vec;
    logic      s1_found, s2_found, s3_found, s4_found;
    logic      s1_vld, s2_vld, s3_vld, s4_vld;

    // any bit set in quarter q
    function automatic logic quarter_any(irq_mask_t act, int unsigned q);
        return |act[q*(NUM_IRQ/PRIO_STAGES) +: NUM_IRQ/PRIO_STAGES];
    endfunction

    // highest set bit inside quarter q
    function automatic irq_vec_t quarter_top(irq_mask_t act, int unsigned q);
        irq_vec_t idx;
        idx = '0;
        for (int i = 0; i < NUM_IRQ/PRIO_STAGES; i++) begin
            if (act[q*(NUM_IRQ/PRIO_STAGES) + i]) begin
                idx = irq_vec_t'(q*(NUM_IRQ/PRIO_STAGES) + i);
            end
        end
        return idx;
    endfunction

    // valid and found flags per stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld   <= 1'b0;
            s2_vld   <= 1'b0;
            s3_vld   <= 1'b0;
            s4_vld   <= 1'b0;
            s1_found <= 1'b0;
            s2_found <= 1'b0;
            s3_found <= 1'b0;
            s4_found <= 1'b0;
        end else begin
            s1_vld   <= 1'b1;
            s2_vld   <= s1_vld;
            s3_vld   <= s2_vld;
            s4_vld   <= s3_vld;
            s1_found <= quarter_any(active, PRIO_STAGES - 1);
            s2_found <= s1_found || quarter_any(s1_act, PRIO_STAGES - 2);
            s3_found <= s2_found || quarter_any(s2_act, PRIO_STAGES - 3);
            s4_found <= s3_found || quarter_any(s3_act, PRIO_STAGES - 4);
        end
    end

    // an earlier find is kept, otherwise search this stage's quarter
    always_ff @(posedge clk) begin
        s1_act <= active;
        s2_act <= s1_act;
        s3_act <= s2_act;
        s1_vec <= quarter_top(active, PRIO_STAGES - 1);
        s2_vec <= s1_found ? s1_vec : quarter_top(s1_act, PRIO_STAGES - 2);
        s3_vec <= s2_found ? s2_vec : quarter_top(s2_act, PRIO_STAGES - 3);
        s4_vec <= s3_found ? s3_vec : quarter_top(s3_act, PRIO_STAGES - 4);
    end

    assign pick_valid = s4_vld && s4_found;
    assign pick_vec   = s4_vec;

endmodule

// ==== irq_pending.sv ====
// edge capture of interrupt sources, pending and enable registers, register file decode
`timescale 1ns/100ps

module irq_pending
    import irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  irq_mask_t irq_src,
    input  logic      bus_valid,
    input  reg_req_t  bus_req,
    output reg_data_t bus_rdata,
    input  logic      claim_valid,
    input  irq_vec_t  claim_vec,
    output irq_mask_t active
);

    irq_mask_t src_q;
    irq_mask_t src_qq;
    irq_mask_t rise;
    irq_mask_t pending;
    irq_mask_t enable;
    irq_mask_t pending_nxt;
    irq_mask_t enable_nxt;
    irq_mask_t sw_set;
    irq_mask_t sw_clr;
    irq_mask_t claim_clr;
    logic      bus_wr;

    // sample sources, then compare with the previous sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q  <= '0;
            src_qq <= '0;
        end else begin
            src_q  <= irq_src;
            src_qq <= src_q;
        end
    end

    assign rise   = src_q & ~src_qq;
    assign bus_wr = bus_valid && bus_req.write;

    assign sw_set = (bus_wr && bus_req.addr == REG_PENDING) ? bus_req.wdata : '0;
    assign sw_clr = (bus_wr && bus_req.addr == REG_CLEAR) ? bus_req.wdata : '0;

    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            claim_clr[i] = claim_valid && (claim_vec == irq_vec_t'(i));
        end
    end

    // set wins over clear on the same bit
    assign pending_nxt = (pending & ~(sw_clr | claim_clr)) | rise | sw_set;
    assign enable_nxt  = (bus_wr && bus_req.addr == REG_ENABLE) ? bus_req.wdata : enable;

    // active follows the updated state so stale picks are filtered exactly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            enable  <= '0;
            active  <= '0;
        end else begin
            pending <= pending_nxt;
            enable  <= enable_nxt;
            active  <= pending_nxt & enable_nxt;
        end
    end

    // read data, zero for writes and for the clear register
    always_comb begin
        bus_rdata = '0;
        if (bus_valid && !bus_req.write) begin
            case (bus_req.addr)
                REG_ENABLE:  bus_rdata = enable;
                REG_PENDING: bus_rdata = pending;
                default:     bus_rdata = '0;
            endcase
        end
    end

endmodule

// ==== irq_pkg.sv ====
// interrupt widths, pipeline depth, register map, bus request struct and host index
package irq_pkg;

    // sources and priority pipeline
    localparam int NUM_IRQ     = 16;
    localparam int PRIO_STAGES = 4;

    // interrupt number and one-bit-per-source vectors
    typedef logic [$clog2(NUM_IRQ)-1:0] irq_vec_t;
    typedef logic [NUM_IRQ-1:0]         irq_mask_t;

    // register bus
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // enable mask, read and write
    localparam reg_addr_t REG_ENABLE  = 2'd0;
    // pending bits, write sets every 1 bit
    localparam reg_addr_t REG_PENDING = 2'd1;
    // write clears every 1 bit, reads as zero
    localparam reg_addr_t REG_CLEAR   = 2'd2;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // 0 is the core, 1 is the debug port
    typedef logic host_sel_t;

endpackage
